/* files.f */
verilog/CpuPkg.sv
verilog/RegisterFile.sv
verilog/FetchStage.sv
verilog/DecodeStage.sv
verilog/ExecuteStage.sv
verilog/MemoryStage.sv
verilog/HazardUnit.sv
verilog/Cpu.sv
testbench/Cpu_assertions.sv
testbench/CpuTb.sv

/* run.sh */
#!/bin/bash
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
	--top-module CpuTb -f files.f -o CpuTbSim

./obj_dir/CpuTbSim | tee sim.log

if grep -q "^No errors$" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

/* testbench/CpuTb.sv */
// Testbench for the five-stage core with ROM, data memory and reference model
module CpuTb;
	timeunit 1ns;
	timeprecision 100ps;
	import CpuPkg::*;

	localparam int DIRECTED_LEN = 31;
	localparam int RANDOM_LEN   = 40;
	localparam int TOTAL_LEN    = 2 * DIRECTED_LEN + RANDOM_LEN;

	logic            clk;
	logic            rst_n;
	logic [PC_W-1:0] instrAddr;
	logic [XLEN-1:0] instrData;
	dataReq_t        dataReq;
	logic            dataReady;
	logic [XLEN-1:0] dataRdData;
	logic            halt;

	logic [XLEN-1:0] prog [256];
	logic [XLEN-1:0] mem [65536];
	logic [XLEN-1:0] modelMem [65536];
	logic [15:0]     expAddr [$];
	logic [XLEN-1:0] expData [$];
	int              errors = 0;
	int              storeIdx = 0;
	int              delayMax = 0;
	int              waitLeft = 0;
	bit              armed = 0;
	bit              checking = 0;

	Cpu Cpu_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.instrAddr  (instrAddr),
		.instrData  (instrData),
		.dataReq    (dataReq),
		.dataReady  (dataReady),
		.dataRdData (dataRdData),
		.halt       (halt)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// Instruction ROM answers in the same cycle
	assign instrData = prog[instrAddr[7:0]];

	function automatic logic [XLEN-1:0] enc(opcode_e op, int rd, int rs, int imm);
		return {op, 5'(rd), 5'(rs), 16'(imm)};
	endfunction

	function automatic logic [XLEN-1:0] encR(opcode_e op, int rd, int rs, int rt);
		return {op, 5'(rd), 5'(rs), 5'(rt), 11'd0};
	endfunction

	function automatic logic [XLEN-1:0] fillWord(logic [15:0] addr);
		return {addr ^ 16'h3c5a, ~addr};
	endfunction

	// Instruction-level interpreter giving the expected stores and memory image
	function automatic void runModel();
		logic [XLEN-1:0] r [32];
		logic [XLEN-1:0] w;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] res;
		logic [15:0]     addr;
		logic [15:0]     pc;
		bit              wr;
		bit              done;
		int              rd;
		pc = '0;
		done = 0;
		for (int i = 0; i < 32; i++)
			r[i] = '0;
		for (int step = 0; step < 1000 && !done; step++) begin
			w = prog[pc[7:0]];
			rd = int'(w[25:21]);
			a = r[w[20:16]];
			b = r[w[15:11]];
			imm = {{16{w[15]}}, w[15:0]};
			addr = 16'(a + imm);
			wr = 1;
			res = '0;
			pc = pc + 16'd1;
			case (w[31:26])
				OpAdd:  res = a + b;
				OpSub:  res = a - b;
				OpAnd:  res = a & b;
				OpOr:   res = a | b;
				OpXor:  res = a ^ b;
				OpSlt:  res = XLEN'($signed(a) < $signed(b));
				OpAddi: res = a + imm;
				OpLoad: res = modelMem[addr];
				OpStore: begin
					wr = 0;
					modelMem[addr] = r[rd];
					expAddr.push_back(addr);
					expData.push_back(r[rd]);
				end
				OpBeq: begin
					wr = 0;
					if (r[rd] == a)
						pc = pc + imm[15:0];
				end
				OpHalt: begin
					wr = 0;
					done = 1;
				end
				default: wr = 0;
			endcase
			if (wr && rd != 0)
				r[rd] = res;
		end
	endfunction

	task automatic loadDirected();
		for (int i = 0; i < 256; i++)
			prog[i] = '0;
		prog[0]  = enc(OpAddi, 1, 0, 7);
		prog[1]  = enc(OpAddi, 2, 0, -3);
		prog[2]  = encR(OpAdd, 3, 1, 2);
		prog[3]  = encR(OpSub, 4, 3, 1);
		prog[4]  = encR(OpAnd, 5, 4, 2);
		prog[5]  = encR(OpOr, 6, 5, 1);
		prog[6]  = encR(OpXor, 7, 6, 2);
		prog[7]  = encR(OpSlt, 8, 2, 1);
		prog[8]  = encR(OpSlt, 9, 1, 2);
		prog[9]  = enc(OpAddi, 0, 0, 5);
		for (int i = 0; i < 8; i++)
			prog[10 + i] = enc(OpStore, (i < 7) ? 3 + i : 0, 0, 1 + i);
		prog[18] = enc(OpLoad, 10, 0, 1);
		prog[19] = encR(OpAdd, 11, 10, 1);
		prog[20] = enc(OpStore, 11, 0, 9);
		prog[21] = enc(OpLoad, 12, 0, 2);
		prog[22] = enc(OpStore, 12, 0, 10);
		prog[23] = enc(OpBeq, 1, 1, 2);
		prog[24] = enc(OpStore, 1, 0, 11);
		prog[25] = enc(OpStore, 2, 0, 12);
		prog[26] = enc(OpBeq, 1, 2, 1);
		prog[27] = enc(OpStore, 2, 0, 13);
		prog[28] = enc(OpStore, 1, 0, 14);
		prog[29] = enc(OpHalt, 0, 0, 0);
		prog[30] = enc(OpStore, 1, 0, 15);
	endtask

	// Forward branches only, and no branch right before the HALT
	task automatic loadRandom();
		int sel;
		for (int i = 0; i < 256; i++)
			prog[i] = '0;
		for (int i = 0; i < RANDOM_LEN - 1; i++) begin
			sel = $urandom % 10;
			if (sel == 9 && i == RANDOM_LEN - 2)
				sel = 6;
			case (sel)
				0, 1, 2, 3, 4, 5:
					prog[i] = encR(opcode_e'(OpAdd + sel), $urandom % 8, $urandom % 8,
						$urandom % 8);
				6: prog[i] = enc(OpAddi, $urandom % 8, $urandom % 8, $urandom);
				7: prog[i] = enc(OpLoad, $urandom % 8, 0, $urandom % 32);
				8: prog[i] = enc(OpStore, $urandom % 8, 0, $urandom % 32);
				default: prog[i] = enc(OpBeq, $urandom % 8, $urandom % 8,
					$urandom % (RANDOM_LEN - 1 - i));
			endcase
		end
		prog[RANDOM_LEN - 1] = enc(OpHalt, 0, 0, 0);
	endtask

	// Data memory with a random wait before each ready
	always @(posedge clk) begin
		if (!rst_n) begin
			dataReady <= 1'b0;
			armed = 0;
		end else if (dataReq.valid && dataReady) begin
			if (dataReq.write)
				mem[dataReq.addr] <= dataReq.wrData;
			dataReady <= 1'b0;
		end else if (dataReq.valid) begin
			if (!armed) begin
				armed = 1;
				waitLeft = (delayMax == 0) ? 0 : int'($urandom % (delayMax + 1));
			end
			if (waitLeft == 0) begin
				dataReady  <= 1'b1;
				dataRdData <= mem[dataReq.addr];
				armed = 0;
			end else begin
				waitLeft--;
			end
		end
	end

	// Compare each completed store with the model's next entry
	always @(posedge clk) begin
		if (checking && rst_n && dataReq.valid && dataReady && dataReq.write) begin
			if (storeIdx >= expAddr.size()) begin
				$display("Store number %0d was not expected by the model", storeIdx);
				errors++;
			end else begin
				if (dataReq.addr != expAddr[storeIdx]) begin
					$display("FAIL dataReq.addr exp %h got %h", expAddr[storeIdx],
						dataReq.addr);
					errors++;
				end
				if (dataReq.wrData != expData[storeIdx]) begin
					$display("FAIL dataReq.wrData exp %h got %h", expData[storeIdx],
						dataReq.wrData);
					errors++;
				end
			end
			storeIdx++;
		end
	end

	task automatic applyReset();
		rst_n <= 1'b0;
		repeat (4) @(posedge clk);
		if (halt !== 1'b0 || dataReq.valid !== 1'b0) begin
			$display("halt or dataReq.valid is not low during reset");
			errors++;
		end
		rst_n <= 1'b1;
	endtask

	task automatic runProgram(int maxDelay);
		for (int i = 0; i < 65536; i++) begin
			mem[i] = fillWord(16'(i));
			modelMem[i] = fillWord(16'(i));
		end
		expAddr.delete();
		expData.delete();
		storeIdx = 0;
		delayMax = maxDelay;
		runModel();
		applyReset();
		checking = 1;
		while (halt !== 1'b1)
			@(posedge clk);
		repeat (10) @(posedge clk);
		checking = 0;
		if (storeIdx != expAddr.size()) begin
			$display("Store count %0d differs from the model's %0d", storeIdx, expAddr.size());
			errors++;
		end
		for (int i = 0; i < 65536; i++) begin
			if (mem[i] != modelMem[i]) begin
				$display("FAIL mem[%h] exp %h got %h", 16'(i), modelMem[i], mem[i]);
				errors++;
			end
		end
	endtask

	initial begin
		repeat (TOTAL_LEN * 8 * 5) @(posedge clk);
		$display("Timeout: the programs did not reach halt in time");
		$display("Errors found");
		$finish;
	end

	initial begin
		void'($urandom(32'h836f_4eaf));
		rst_n      = 1'b0;
		dataReady  = 1'b0;
		dataRdData = '0;
		loadDirected();
		runProgram(0);
		runProgram(3);
		loadRandom();
		runProgram(3);
		// Assertion failures of the bound checker count as errors
		errors += Cpu_i.CpuAssertions_i.failCount;
		$display("Error count: %0d", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* testbench/Cpu_assertions.sv */
// Data port and halt assertions attached to the core top level
module CpuAssertions (
	input logic             clk,
	input logic             rst_n,
	input CpuPkg::dataReq_t dataReq,
	input logic             dataReady,
	input logic             halt
);
	timeunit 1ns;
	timeprecision 100ps;
	import CpuPkg::*;

	int failCount = 0;

	// Request held while the memory is not ready
	assert property (@(posedge clk) disable iff (!rst_n)
		dataReq.valid && !dataReady |=> $stable(dataReq))
		else begin
			$error("data request changed while waiting");
			failCount++;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		halt |=> halt)
		else begin
			$error("halt dropped");
			failCount++;
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		$past(halt, 2) |-> !dataReq.valid)
		else begin
			$error("data request after halt");
			failCount++;
		end

endmodule

bind Cpu CpuAssertions CpuAssertions_i (
	.clk       (clk),
	.rst_n     (rst_n),
	.dataReq   (dataReq),
	.dataReady (dataReady),
	.halt      (halt)
);

/* verilog/Cpu.sv */
// Top of the five-stage core connecting the stages and the hazard unit
module Cpu (
	input  logic                    clk,
	input  logic                    rst_n,
	output logic [CpuPkg::PC_W-1:0] instrAddr,
	input  logic [CpuPkg::XLEN-1:0] instrData,
	output CpuPkg::dataReq_t        dataReq,
	input  logic                    dataReady,
	input  logic [CpuPkg::XLEN-1:0] dataRdData,
	output logic                    halt
);
	import CpuPkg::*;

	pipeCtrl_t       ctrl;
	fetchPkt_t       fetchPkt;
	decodePkt_t      decodePkt;
	execPkt_t        execPkt;
	wbPkt_t          wbPkt;
	logic            haltSeen;
	logic            redirectValid;
	logic [PC_W-1:0] redirectPc;
	fwdSel_e         fwdA;
	fwdSel_e         fwdB;

	FetchStage FetchStage_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl),
		.haltSeen   (haltSeen),
		.redirectPc (redirectPc),
		.instrAddr  (instrAddr),
		.instrData  (instrData),
		.fetchPkt   (fetchPkt)
	);

	DecodeStage DecodeStage_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.fetchPkt  (fetchPkt),
		.wbPkt     (wbPkt),
		.decodePkt (decodePkt),
		.haltSeen  (haltSeen)
	);

	ExecuteStage ExecuteStage_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.ctrl          (ctrl),
		.decodePkt     (decodePkt),
		.fwdA          (fwdA),
		.fwdB          (fwdB),
		.wbPkt         (wbPkt),
		.redirectValid (redirectValid),
		.redirectPc    (redirectPc),
		.execPkt       (execPkt)
	);

	MemoryStage MemoryStage_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.ctrl       (ctrl),
		.execPkt    (execPkt),
		.dataReq    (dataReq),
		.dataReady  (dataReady),
		.dataRdData (dataRdData),
		.wbPkt      (wbPkt),
		.halt       (halt)
	);

	// B-side source follows the same rule as the register read in decode
	HazardUnit HazardUnit_i (
		.ifRs          (fetchPkt.instr.rs),
		.ifRt          (operandBReg(fetchPkt.instr)),
		.exRs          (decodePkt.rs),
		.exRt          (decodePkt.rt),
		.exRd          (decodePkt.rd),
		.exMemRead     (decodePkt.memRead),
		.memRd         (execPkt.rd),
		.memWriteEn    (execPkt.writeEn),
		.memRead       (execPkt.memRead),
		.wbRd          (wbPkt.rd),
		.wbWriteEn     (wbPkt.writeEn),
		.redirectValid (redirectValid),
		.dataValid     (dataReq.valid),
		.dataReady     (dataReady),
		.ctrl          (ctrl),
		.fwdA          (fwdA),
		.fwdB          (fwdB)
	);

endmodule

/* verilog/CpuPkg.sv */
// Core package with widths, opcodes, instruction fields and pipeline packets
package CpuPkg;

	localparam int XLEN        = 32;
	localparam int REG_ADDR_W  = 5;
	localparam int NUM_REGS    = 32;
	localparam int PC_W        = 16;
	localparam int DATA_ADDR_W = 16;
	localparam logic [PC_W-1:0] RESET_PC = '0;

	typedef enum logic [5:0] {
		OpNop   = 6'd0,
		OpAdd   = 6'd1,
		OpSub   = 6'd2,
		OpAnd   = 6'd3,
		OpOr    = 6'd4,
		OpXor   = 6'd5,
		OpSlt   = 6'd6,
		OpAddi  = 6'd7,
		OpLoad  = 6'd8,
		OpStore = 6'd9,
		OpBeq   = 6'd10,
		OpHalt  = 6'd11
	} opcode_e;

	typedef enum logic [1:0] {
		FwdNone = 2'd0,
		FwdMem  = 2'd1,
		FwdWb   = 2'd2
	} fwdSel_e;

	// rt lives in the top five bits of imm
	typedef struct packed {
		opcode_e               op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs;
		logic [15:0]           imm;
	} instr_t;

	typedef struct packed {
		logic            valid;
		logic [PC_W-1:0] pc;
		instr_t          instr;
	} fetchPkt_t;

	typedef struct packed {
		logic                  valid;
		opcode_e               op;
		logic [REG_ADDR_W-1:0] rd;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [XLEN-1:0]       opA;
		logic [XLEN-1:0]       opB;
		logic [15:0]           imm;
		logic [PC_W-1:0]       pc;
		logic                  writeEn;
		logic                  memRead;
		logic                  memWrite;
		logic                  isBranch;
		logic                  isHalt;
	} decodePkt_t;

	typedef struct packed {
		logic                  valid;
		logic [REG_ADDR_W-1:0] rd;
		logic                  writeEn;
		logic                  memRead;
		logic                  memWrite;
		logic                  isHalt;
		logic [XLEN-1:0]       result;
		logic [XLEN-1:0]       storeData;
	} execPkt_t;

	typedef struct packed {
		logic                  writeEn;
		logic [REG_ADDR_W-1:0] rd;
		logic [XLEN-1:0]       data;
		logic                  isHalt;
	} wbPkt_t;

	typedef struct packed {
		logic                   valid;
		logic                   write;
		logic [DATA_ADDR_W-1:0] addr;
		logic [XLEN-1:0]        wrData;
	} dataReq_t;

	typedef struct packed {
		logic fetchEn;
		logic decodeEn;
		logic decodeBubble;
		logic frontFlush;
		logic backEn;
	} pipeCtrl_t;

	// Second source register; stores and branches read rd there
	function automatic logic [REG_ADDR_W-1:0] operandBReg(instr_t instr);
		case (instr.op)
			OpAdd, OpSub, OpAnd, OpOr, OpXor, OpSlt: return instr.imm[15:11];
			OpStore, OpBeq:                          return instr.rd;
			default:                                 return '0;
		endcase
	endfunction

endpackage

/* verilog/DecodeStage.sv */
// Decode stage with opcode decoding, operand read, halt tracking and ID/EX
module DecodeStage (
	input  logic                clk,
	input  logic                rst_n,
	input  CpuPkg::pipeCtrl_t   ctrl,
	input  CpuPkg::fetchPkt_t   fetchPkt,
	input  CpuPkg::wbPkt_t      wbPkt,
	output CpuPkg::decodePkt_t  decodePkt,
	output logic                haltSeen
);
	import CpuPkg::*;

	instr_t                instr;
	logic [REG_ADDR_W-1:0] srcB;
	logic [XLEN-1:0]       rdDataA;
	logic [XLEN-1:0]       rdDataB;
	logic                  squash;
	decodePkt_t            entry;

	assign instr = fetchPkt.instr;
	assign srcB  = operandBReg(instr);

	RegisterFile RegisterFile_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.readAddrA (instr.rs),
		.readAddrB (srcB),
		.writeAddr (wbPkt.rd),
		.writeEn   (wbPkt.writeEn),
		.writeData (wbPkt.data),
		.readDataA (rdDataA),
		.readDataB (rdDataB)
	);

	assign squash = ctrl.frontFlush || ctrl.decodeBubble || haltSeen || !fetchPkt.valid;

	always_comb begin
		entry          = '0;
		entry.valid    = 1'b1;
		entry.op       = instr.op;
		entry.rd       = instr.rd;
		entry.rs       = instr.rs;
		entry.rt       = srcB;
		entry.opA      = rdDataA;
		entry.opB      = rdDataB;
		entry.imm      = instr.imm;
		entry.pc       = fetchPkt.pc;
		case (instr.op)
			OpAdd, OpSub, OpAnd, OpOr, OpXor, OpSlt, OpAddi: entry.writeEn = 1'b1;
			OpLoad: begin
				entry.writeEn = 1'b1;
				entry.memRead = 1'b1;
			end
			OpStore: entry.memWrite = 1'b1;
			OpBeq:   entry.isBranch = 1'b1;
			OpHalt:  entry.isHalt   = 1'b1;
			default: entry.op       = OpNop;
		endcase
		// Writes to r0 are dropped here
		if (instr.rd == '0)
			entry.writeEn = 1'b0;
		if (squash) begin
			entry.valid    = 1'b0;
			entry.writeEn  = 1'b0;
			entry.memRead  = 1'b0;
			entry.memWrite = 1'b0;
			entry.isBranch = 1'b0;
			entry.isHalt   = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			decodePkt.valid    <= 1'b0;
			decodePkt.writeEn  <= 1'b0;
			decodePkt.memRead  <= 1'b0;
			decodePkt.memWrite <= 1'b0;
			decodePkt.isBranch <= 1'b0;
			decodePkt.isHalt   <= 1'b0;
			haltSeen           <= 1'b0;
		end else if (ctrl.decodeEn) begin
			decodePkt <= entry;
			if (entry.isHalt)
				haltSeen <= 1'b1;
		end
	end

endmodule

/* verilog/ExecuteStage.sv */
// Execute stage with forwarding, ALU, branch resolution and the EX/MEM register
module ExecuteStage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  CpuPkg::pipeCtrl_t       ctrl,
	input  CpuPkg::decodePkt_t      decodePkt,
	input  CpuPkg::fwdSel_e         fwdA,
	input  CpuPkg::fwdSel_e         fwdB,
	input  CpuPkg::wbPkt_t          wbPkt,
	output logic                    redirectValid,
	output logic [CpuPkg::PC_W-1:0] redirectPc,
	output CpuPkg::execPkt_t        execPkt
);
	import CpuPkg::*;

	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [XLEN-1:0] immExt;
	logic [XLEN-1:0] result;

	function automatic logic [XLEN-1:0] fwdMux(fwdSel_e sel, logic [XLEN-1:0] regVal);
		case (sel)
			FwdMem:  return execPkt.result;
			FwdWb:   return wbPkt.data;
			default: return regVal;
		endcase
	endfunction

	assign opA    = fwdMux(fwdA, decodePkt.opA);
	assign opB    = fwdMux(fwdB, decodePkt.opB);
	assign immExt = XLEN'($signed(decodePkt.imm));

	// Addi, load and store all share the address adder
	always_comb begin
		case (decodePkt.op)
			OpAdd:   result = opA + opB;
			OpSub:   result = opA - opB;
			OpAnd:   result = opA & opB;
			OpOr:    result = opA | opB;
			OpXor:   result = opA ^ opB;
			OpSlt:   result = XLEN'($signed(opA) < $signed(opB));
			default: result = opA + immExt;
		endcase
	end

	// BEQ compares rs (A side) against rd (B side)
	assign redirectValid = decodePkt.valid && decodePkt.isBranch && (opA == opB);
	assign redirectPc    = decodePkt.pc + PC_W'(1) + PC_W'($signed(decodePkt.imm));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			execPkt.valid    <= 1'b0;
			execPkt.writeEn  <= 1'b0;
			execPkt.memRead  <= 1'b0;
			execPkt.memWrite <= 1'b0;
			execPkt.isHalt   <= 1'b0;
		end else if (ctrl.backEn) begin
			execPkt.valid     <= decodePkt.valid;
			execPkt.rd        <= decodePkt.rd;
			execPkt.writeEn   <= decodePkt.writeEn;
			execPkt.memRead   <= decodePkt.memRead;
			execPkt.memWrite  <= decodePkt.memWrite;
			execPkt.isHalt    <= decodePkt.isHalt;
			execPkt.result    <= result;
			execPkt.storeData <= opB;
		end
	end

endmodule

/* verilog/FetchStage.sv */
// Fetch stage holding the program counter and the IF/ID register
module FetchStage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  CpuPkg::pipeCtrl_t       ctrl,
	input  logic                    haltSeen,
	input  logic [CpuPkg::PC_W-1:0] redirectPc,
	output logic [CpuPkg::PC_W-1:0] instrAddr,
	input  logic [CpuPkg::XLEN-1:0] instrData,
	output CpuPkg::fetchPkt_t       fetchPkt
);
	import CpuPkg::*;

	logic [PC_W-1:0] pc;

	// Instruction memory answers in the same cycle
	assign instrAddr = pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc             <= RESET_PC;
			fetchPkt.valid <= 1'b0;
		end else if (ctrl.frontFlush) begin
			pc             <= redirectPc;
			fetchPkt.valid <= 1'b0;
		end else if (ctrl.fetchEn) begin
			// Nothing past a HALT enters the pipe
			fetchPkt.valid <= !haltSeen;
			fetchPkt.pc    <= pc;
			fetchPkt.instr <= instrData;
			if (!haltSeen)
				pc <= pc + PC_W'(1);
		end
	end

endmodule

/* verilog/HazardUnit.sv */
// Hazard unit deriving forwarding selects, stalls and flushes
module HazardUnit (
	input  logic [CpuPkg::REG_ADDR_W-1:0] ifRs,
	input  logic [CpuPkg::REG_ADDR_W-1:0] ifRt,
	input  logic [CpuPkg::REG_ADDR_W-1:0] exRs,
	input  logic [CpuPkg::REG_ADDR_W-1:0] exRt,
	input  logic [CpuPkg::REG_ADDR_W-1:0] exRd,
	input  logic                          exMemRead,
	input  logic [CpuPkg::REG_ADDR_W-1:0] memRd,
	input  logic                          memWriteEn,
	input  logic                          memRead,
	input  logic [CpuPkg::REG_ADDR_W-1:0] wbRd,
	input  logic                          wbWriteEn,
	input  logic                          redirectValid,
	input  logic                          dataValid,
	input  logic                          dataReady,
	output CpuPkg::pipeCtrl_t             ctrl,
	output CpuPkg::fwdSel_e               fwdA,
	output CpuPkg::fwdSel_e               fwdB
);
	import CpuPkg::*;

	logic memWait;
	logic loadUse;

	// Load data is not ready in MEM, so only ALU results forward from there
	function automatic fwdSel_e pickSource(logic [REG_ADDR_W-1:0] src);
		if (memWriteEn && !memRead && memRd == src)
			return FwdMem;
		if (wbWriteEn && wbRd == src)
			return FwdWb;
		return FwdNone;
	endfunction

	assign fwdA = pickSource(exRs);
	assign fwdB = pickSource(exRt);

	assign memWait = dataValid && !dataReady;
	assign loadUse = exMemRead && exRd != '0 && (exRd == ifRs || exRd == ifRt);

	always_comb begin
		ctrl.backEn       = !memWait;
		ctrl.decodeEn     = !memWait;
		ctrl.decodeBubble = loadUse;
		ctrl.fetchEn      = !memWait && !loadUse;
		ctrl.frontFlush   = redirectValid && !memWait;
	end

endmodule

/* verilog/MemoryStage.sv */
// Memory stage driving the data port, the MEM/WB register and the halt flag
module MemoryStage (
	input  logic                    clk,
	input  logic                    rst_n,
	input  CpuPkg::pipeCtrl_t       ctrl,
	input  CpuPkg::execPkt_t        execPkt,
	output CpuPkg::dataReq_t        dataReq,
	input  logic                    dataReady,
	input  logic [CpuPkg::XLEN-1:0] dataRdData,
	output CpuPkg::wbPkt_t          wbPkt,
	output logic                    halt
);
	import CpuPkg::*;

	// EX/MEM holds while the port is busy, so the request stays stable
	always_comb begin
		dataReq.valid  = execPkt.valid && (execPkt.memRead || execPkt.memWrite);
		dataReq.write  = execPkt.memWrite;
		dataReq.addr   = execPkt.result[DATA_ADDR_W-1:0];
		dataReq.wrData = execPkt.storeData;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wbPkt.writeEn <= 1'b0;
			wbPkt.isHalt  <= 1'b0;
		end else if (ctrl.backEn) begin
			wbPkt.writeEn <= execPkt.writeEn;
			wbPkt.rd      <= execPkt.rd;
			wbPkt.data    <= execPkt.memRead ? dataRdData : execPkt.result;
			wbPkt.isHalt  <= execPkt.isHalt;
		end
	end

	// Sticky until reset
	always_ff @(posedge clk) begin
		if (!rst_n)
			halt <= 1'b0;
		else if (wbPkt.isHalt)
			halt <= 1'b1;
	end

endmodule

/* verilog/RegisterFile.sv */
// Register file of 32 words with a zero register and write-through reads
module RegisterFile (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [CpuPkg::REG_ADDR_W-1:0] readAddrA,
	input  logic [CpuPkg::REG_ADDR_W-1:0] readAddrB,
	input  logic [CpuPkg::REG_ADDR_W-1:0] writeAddr,
	input  logic                          writeEn,
	input  logic [CpuPkg::XLEN-1:0]       writeData,
	output logic [CpuPkg::XLEN-1:0]       readDataA,
	output logic [CpuPkg::XLEN-1:0]       readDataB
);
	import CpuPkg::*;

	logic [XLEN-1:0] regs [NUM_REGS];

	// Same-cycle write wins over the stored word
	function automatic logic [XLEN-1:0] readPort(logic [REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		if (writeEn && writeAddr == addr)
			return writeData;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	assign readDataA = readPort(readAddrA);
	assign readDataB = readPort(readAddrB);

endmodule
